//--- design/cdc_pkg.sv
// CDC word bridge shared types

package cdc_pkg;

  // ---------------------------------------------------------------------
  // transported word
  // ---------------------------------------------------------------------

  // one 32-bit payload word, carried unmodified
  typedef logic [31:0] cdc_word_t;

  // ---------------------------------------------------------------------
  // handshake controller states
  // ---------------------------------------------------------------------

  // source side, c_clk domain
  typedef enum logic [1:0] {
    src_idle  = 2'd0,
    src_req   = 2'd1,
    src_clear = 2'd2
  } src_state_t;

  // sink side, p_clk domain
  typedef enum logic {
    dst_idle = 1'b0,
    dst_ack  = 1'b1
  } dst_state_t;

  // flops per synchronizer chain, 2 or 3 are sensible
  parameter int SYNC_STAGES_DEFAULT = 2;

endpackage

//--- design/word_capture.sv
// Source-side word capture
`timescale 1ns/1ps

module word_capture
  import cdc_pkg::*;
(
  input  logic      c_clk,
  input  logic      c_reset,

  // upstream handshake
  input  logic      in_srdy,
  output logic      in_drdy,
  input  cdc_word_t in_data,

  // request toward the synchronizer
  output logic      req_srdy,
  input  logic      req_drdy,
  output cdc_word_t cap_data
);

  // ---------------------------------------------------------------------
  // holding register
  // ---------------------------------------------------------------------

  // set while a word sits waiting for the crossing
  logic      full;
  // payload, stable for as long as full is set
  cdc_word_t data_q;
  // upstream transfer this cycle
  logic      load;

  // only one word in flight at a time
  assign in_drdy = ~full;
  assign load    = in_srdy & in_drdy;

  // full flag
  always_ff @(posedge c_clk or posedge c_reset)
  begin
    if (c_reset)
    begin
      full <= 1'b0;
    end
    else if (load)
    begin
      // word captured, request goes up next edge
      full <= 1'b1;
    end
    else if (req_drdy)
    begin
      // sink has taken the word
      full <= 1'b0;
    end
  end

  // data register
  always_ff @(posedge c_clk)
  begin
    // only written when empty, so the crossed bits never move
    // while the request is up
    if (load)
    begin
      data_q <= in_data;
    end
  end

  // ---------------------------------------------------------------------
  // request side
  // ---------------------------------------------------------------------

  // request level follows the full flag
  assign req_srdy = full;

  // data goes straight to the sink domain, unsynchronized
  assign cap_data = data_q;

endmodule

//--- design/hs_sync.sv
// Four-phase handshake synchronizer
`timescale 1ns/1ps

module hs_sync
  import cdc_pkg::*;
#(
  parameter int sync_stages = SYNC_STAGES_DEFAULT
)
(
  // source domain
  input  logic c_clk,
  input  logic c_reset,
  input  logic req_srdy,
  output logic req_drdy,

  // sink domain
  input  logic p_clk,
  input  logic p_reset,
  output logic dlv_srdy,
  input  logic dlv_drdy
);

  // source side controller
  src_state_t             src_state;
  src_state_t             src_state_nxt;
  // registered request level sent across
  logic                   launch;
  logic                   launch_nxt;
  // acknowledge chain into c_clk
  logic [sync_stages-1:0] ack_chain;
  logic                   ack_sync;

  // sink side controller
  dst_state_t             dst_state;
  dst_state_t             dst_state_nxt;
  // launch chain into p_clk
  logic [sync_stages-1:0] launch_chain;
  logic                   launch_sync;
  // acknowledge level sent back
  logic                   ack;

  // ---------------------------------------------------------------------
  // source domain, c_clk
  // ---------------------------------------------------------------------

  // last flop of the chain is the usable copy
  assign ack_sync = ack_chain[sync_stages-1];

  always_comb
  begin
    launch_nxt    = 1'b0;
    req_drdy      = 1'b0;
    src_state_nxt = src_state;

    case (src_state)
      src_idle:
      begin
        // new word waiting, raise launch
        if (req_srdy)
        begin
          launch_nxt    = 1'b1;
          src_state_nxt = src_req;
        end
      end

      src_req:
      begin
        // hold launch until the sink answers
        launch_nxt = 1'b1;
        if (ack_sync)
        begin
          // one-cycle pulse back to capture
          req_drdy      = 1'b1;
          src_state_nxt = src_clear;
        end
      end

      src_clear:
      begin
        // launch already dropped, wait for ack to follow
        if (!ack_sync)
        begin
          src_state_nxt = src_idle;
        end
      end

      default:
      begin
        src_state_nxt = src_idle;
      end
    endcase
  end

  always_ff @(posedge c_clk or posedge c_reset)
  begin
    if (c_reset)
    begin
      src_state <= src_idle;
      launch    <= 1'b0;
    end
    else
    begin
      src_state <= src_state_nxt;
      launch    <= launch_nxt;
    end
  end

  // ack crossing into c_clk
  always_ff @(posedge c_clk or posedge c_reset)
  begin
    if (c_reset)
    begin
      ack_chain <= '0;
    end
    else
    begin
      ack_chain <= {ack_chain[sync_stages-2:0], ack};
    end
  end

  // ---------------------------------------------------------------------
  // sink domain, p_clk
  // ---------------------------------------------------------------------

  // launch crossing into p_clk
  always_ff @(posedge p_clk or posedge p_reset)
  begin
    if (p_reset)
    begin
      launch_chain <= '0;
    end
    else
    begin
      launch_chain <= {launch_chain[sync_stages-2:0], launch};
    end
  end

  assign launch_sync = launch_chain[sync_stages-1];

  always_comb
  begin
    dlv_srdy      = 1'b0;
    dst_state_nxt = dst_state;

    case (dst_state)
      dst_idle:
      begin
        // offer the word while launch is seen high
        dlv_srdy = launch_sync;
        if (launch_sync && dlv_drdy)
        begin
          dst_state_nxt = dst_ack;
        end
      end

      dst_ack:
      begin
        // word taken, hold ack until launch falls
        if (!launch_sync)
        begin
          dst_state_nxt = dst_idle;
        end
      end

      default:
      begin
        dst_state_nxt = dst_idle;
      end
    endcase
  end

  always_ff @(posedge p_clk or posedge p_reset)
  begin
    if (p_reset)
    begin
      dst_state <= dst_idle;
    end
    else
    begin
      dst_state <= dst_state_nxt;
    end
  end

  // ack decoded from the state flop alone, glitch free into the chain
  assign ack = (dst_state == dst_ack);

endmodule

//--- design/word_release.sv
// Sink-side word release
`timescale 1ns/1ps

module word_release
  import cdc_pkg::*;
(
  input  logic      p_clk,
  input  logic      p_reset,

  // delivery from the synchronizer
  input  logic      dlv_srdy,
  output logic      dlv_drdy,
  input  cdc_word_t cap_data,

  // downstream handshake
  output logic      out_srdy,
  input  logic      out_drdy,
  output cdc_word_t out_data
);

  // ---------------------------------------------------------------------
  // output register
  // ---------------------------------------------------------------------

  // set while a word waits for downstream
  logic      full;
  // registered copy of the crossed word
  cdc_word_t data_q;
  // delivery and downstream transfers
  logic      take;
  logic      give;

  // closed to deliveries while holding a word
  assign dlv_drdy = ~full;
  assign take     = dlv_srdy & dlv_drdy;
  assign give     = out_srdy & out_drdy;

  // full flag
  always_ff @(posedge p_clk or posedge p_reset)
  begin
    if (p_reset)
    begin
      full <= 1'b0;
    end
    else if (take)
    begin
      full <= 1'b1;
    end
    else if (give)
    begin
      // downstream accepted, reopen for the next delivery
      full <= 1'b0;
    end
  end

  // data register
  always_ff @(posedge p_clk)
  begin
    // cap_data has sat still for the whole sync delay by now
    if (take)
    begin
      data_q <= cap_data;
    end
  end

  // ---------------------------------------------------------------------
  // downstream side
  // ---------------------------------------------------------------------

  // word and valid hold together under back-pressure
  assign out_srdy = full;
  assign out_data = data_q;

endmodule

//--- design/cdc_word_bridge.sv
// CDC word bridge top level
`timescale 1ns/1ps

module cdc_word_bridge
  import cdc_pkg::*;
#(
  parameter int sync_stages = SYNC_STAGES_DEFAULT
)
(
  // source domain
  input  logic      c_clk,
  input  logic      c_reset,
  input  logic      in_srdy,
  output logic      in_drdy,
  input  cdc_word_t in_data,

  // sink domain
  input  logic      p_clk,
  input  logic      p_reset,
  output logic      out_srdy,
  input  logic      out_drdy,
  output cdc_word_t out_data
);

  // ---------------------------------------------------------------------
  // internal paths
  // ---------------------------------------------------------------------

  // request path, c_clk
  logic      req_srdy;
  logic      req_drdy;
  // held word, crosses without synchronization
  cdc_word_t cap_data;
  // delivery path, p_clk
  logic      dlv_srdy;
  logic      dlv_drdy;

  // capture stage
  word_capture u_capture (
    .c_clk    (c_clk),
    .c_reset  (c_reset),
    .in_srdy  (in_srdy),
    .in_drdy  (in_drdy),
    .in_data  (in_data),
    .req_srdy (req_srdy),
    .req_drdy (req_drdy),
    .cap_data (cap_data)
  );

  // control crossing
  hs_sync #(
    .sync_stages (sync_stages)
  ) u_sync (
    .c_clk    (c_clk),
    .c_reset  (c_reset),
    .req_srdy (req_srdy),
    .req_drdy (req_drdy),
    .p_clk    (p_clk),
    .p_reset  (p_reset),
    .dlv_srdy (dlv_srdy),
    .dlv_drdy (dlv_drdy)
  );

  // release stage
  word_release u_release (
    .p_clk    (p_clk),
    .p_reset  (p_reset),
    .dlv_srdy (dlv_srdy),
    .dlv_drdy (dlv_drdy),
    .cap_data (cap_data),
    .out_srdy (out_srdy),
    .out_drdy (out_drdy),
    .out_data (out_data)
  );

endmodule

//--- tests/tb_clock.sv
// Testbench clock source
`timescale 1ns/1ps

module tb_clock
#(
  // full period in ns
  parameter real period = 4.0
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  // free running, first rising edge after half a period
  always
  begin
    #(period / 2.0) clk = ~clk;
  end

endmodule

//--- tests/hs_sync_props.sv
// Handshake synchronizer properties
`timescale 1ns/1ps

module hs_sync_props
  import cdc_pkg::*;
(
  input logic       c_clk,
  input logic       c_reset,
  input logic       p_clk,
  input logic       p_reset,
  input src_state_t src_state,
  input dst_state_t dst_state,
  input logic       req_drdy,
  input logic       dlv_srdy
);

  // failed properties so far
  int unsigned fail_count;

  // ---------------------------------------------------------------------
  // source controller, c_clk
  // ---------------------------------------------------------------------

  // req is left only through the acknowledge pulse
  src_req_hold: assert property (@(posedge c_clk) disable iff (c_reset)
    (src_state == src_req && !req_drdy) |=> (src_state == src_req))
    else
    begin
      fail_count++;
      $error("source controller left req without req_drdy");
    end

  src_req_exit: assert property (@(posedge c_clk) disable iff (c_reset)
    (src_state == src_req && req_drdy) |=> (src_state == src_clear))
    else
    begin
      fail_count++;
      $error("source controller missed clear after req_drdy");
    end

  // single-cycle acknowledge toward capture
  ack_pulse: assert property (@(posedge c_clk) disable iff (c_reset)
    req_drdy |=> !req_drdy)
    else
    begin
      fail_count++;
      $error("req_drdy held for more than one c_clk cycle");
    end

  // ---------------------------------------------------------------------
  // sink controller, p_clk
  // ---------------------------------------------------------------------

  // no second offer while the acknowledge is up
  no_offer_in_ack: assert property (@(posedge p_clk) disable iff (p_reset)
    (dst_state == dst_ack) |-> !dlv_srdy)
    else
    begin
      fail_count++;
      $error("dlv_srdy high in sink ack state");
    end

endmodule

//--- tests/tb_cdc_word_bridge.sv
// CDC word bridge testbench
`timescale 1ns/1ps

module tb_cdc_word_bridge
  import cdc_pkg::*;
();

  localparam int  reset_cycles = 16;
  localparam int  total_words  = 1 + 64 + 32 + 32;
  // 200 ns per word on top of the slower reset
  localparam real watchdog_ns  = total_words * 200.0 + reset_cycles * 7.0;

  logic      c_clk;
  logic      p_clk;
  logic      c_reset;
  logic      p_reset;
  logic      in_srdy;
  logic      in_drdy;
  cdc_word_t in_data;
  logic      out_srdy;
  logic      out_drdy;
  cdc_word_t out_data;

  // scoreboard, in arrival order
  cdc_word_t exp_q[$];
  int        tx_count;
  int        rx_count;
  string     test_name;
  // sink stall pattern on or off
  bit        stall_mode;
  // output hold tracking
  bit        hold_valid;
  cdc_word_t hold_data;
  int        hold_cycles;
  int        bp_checks;

  tb_clock #(.period(4.0)) u_c_clock (.clk(c_clk));
  tb_clock #(.period(7.0)) u_p_clock (.clk(p_clk));

  cdc_word_bridge u_dut (
    .c_clk    (c_clk),
    .c_reset  (c_reset),
    .in_srdy  (in_srdy),
    .in_drdy  (in_drdy),
    .in_data  (in_data),
    .p_clk    (p_clk),
    .p_reset  (p_reset),
    .out_srdy (out_srdy),
    .out_drdy (out_drdy),
    .out_data (out_data)
  );

  bind hs_sync hs_sync_props u_props (
    .c_clk     (c_clk),
    .c_reset   (c_reset),
    .p_clk     (p_clk),
    .p_reset   (p_reset),
    .src_state (src_state),
    .dst_state (dst_state),
    .req_drdy  (req_drdy),
    .dlv_srdy  (dlv_srdy)
  );

  // ---------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input cdc_word_t exp, input cdc_word_t act);
    if (act !== exp)
    begin
      abort_run($sformatf("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      abort_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
    end
  endtask

  // in-order lossless model, oldest accepted word comes out first
  function automatic cdc_word_t next_expected();
    return exp_q.pop_front();
  endfunction

  // called and returns 1 ns after a c_clk edge
  task automatic send_word(input cdc_word_t word, input int gap);
    in_srdy = 1'b1;
    in_data = word;
    do
    begin
      @(posedge c_clk);
    end
    while (!in_drdy);
    #1;
    in_srdy = 1'b0;
    repeat (gap)
    begin
      @(posedge c_clk);
      #1;
    end
  endtask

  task automatic wait_drained();
    wait (rx_count == tx_count);
    // room for a late duplicate to show up
    repeat (8) @(posedge p_clk);
    @(posedge c_clk);
    #1;
  endtask

  // ---------------------------------------------------------------------
  // monitors and sink driver
  // ---------------------------------------------------------------------

  // source transfers feed the scoreboard
  always @(posedge c_clk)
  begin
    if (!c_reset && in_srdy && in_drdy)
    begin
      exp_q.push_back(in_data);
      tx_count++;
    end
  end

  // compare every out transfer, watch holds under back-pressure
  always @(posedge p_clk)
  begin
    if (!p_reset)
    begin
      if (hold_valid)
      begin
        check_flag($sformatf("%s out_srdy hold", test_name), 1'b1, out_srdy);
        check_word($sformatf("%s out_data hold", test_name), hold_data, out_data);
      end
      // long stall with the source offering, capture must be stuck full
      if (stall_mode && in_srdy && hold_cycles >= 8)
      begin
        check_flag($sformatf("%s in_drdy", test_name), 1'b0, in_drdy);
        bp_checks++;
      end
      if (out_srdy && out_drdy)
      begin
        if (exp_q.size() == 0)
        begin
          abort_run($sformatf("%s: output word 0x%08h with no input word", test_name, out_data));
        end
        check_word(test_name, next_expected(), out_data);
        rx_count++;
      end
      hold_valid  = out_srdy && !out_drdy;
      hold_data   = out_data;
      hold_cycles = hold_valid ? hold_cycles + 1 : 0;
    end
  end

  // bound synchronizer properties
  always @(u_dut.u_sync.u_props.fail_count)
  begin
    if (u_dut.u_sync.u_props.fail_count != 0)
    begin
      abort_run($sformatf("handshake synchronizer property failed in %s", test_name));
    end
  end

  // ready stretches of 1..4, stall stretches of 1..16 p_clk cycles
  initial
  begin : sink_driver
    int run;
    run      = 0;
    out_drdy = 1'b0;
    forever
    begin
      @(posedge p_clk);
      #1;
      if (!stall_mode)
      begin
        out_drdy = 1'b1;
      end
      else if (run > 0)
      begin
        run--;
      end
      else
      begin
        out_drdy = ~out_drdy;
        run      = out_drdy ? $urandom_range(3, 0) : $urandom_range(15, 0);
      end
    end
  end

  initial
  begin
    #(watchdog_ns);
    abort_run($sformatf("timeout in %s: %0d of %0d words received", test_name, rx_count,
                        tx_count));
  end

  // ---------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------

  initial
  begin
    c_reset    = 1'b1;
    p_reset    = 1'b1;
    in_srdy    = 1'b0;
    in_data    = '0;
    stall_mode = 1'b0;
    test_name  = "reset";
    void'($urandom(32'hf728ed59));
    fork
      begin
        repeat (reset_cycles) @(posedge c_clk);
        #1 c_reset = 1'b0;
      end
      begin
        repeat (reset_cycles) @(posedge p_clk);
        #1 p_reset = 1'b0;
      end
    join
    @(posedge c_clk);
    #1;

    test_name = "reset_state";
    check_flag(test_name, 1'b1, in_drdy);
    check_flag(test_name, 1'b0, out_srdy);

    test_name = "single_word";
    send_word(32'ha5c3_0f1e, 0);
    wait_drained();

    // source always offering
    test_name = "back_to_back";
    repeat (64) send_word($urandom, 0);
    wait_drained();

    test_name = "source_gaps";
    repeat (32) send_word($urandom, $urandom_range(5, 0));
    wait_drained();

    test_name  = "sink_stalls";
    stall_mode = 1'b1;
    repeat (32) send_word($urandom, 0);
    wait_drained();
    stall_mode = 1'b0;
    check_flag("sink_stalls back-pressure seen", 1'b1, bp_checks > 0);

    if (exp_q.size() == 0 && tx_count == total_words && rx_count == total_words)
    begin
      $display("All tests passed");
      $finish;
    end
    else
    begin
      abort_run($sformatf("%0d words sent, %0d received, %0d left in scoreboard",
                          tx_count, rx_count, exp_q.size()));
    end
  end

endmodule

//--- vlog.f
design/cdc_pkg.sv
design/word_capture.sv
design/hs_sync.sv
design/word_release.sv
design/cdc_word_bridge.sv
tests/tb_clock.sv
tests/hs_sync_props.sv
tests/tb_cdc_word_bridge.sv

//--- Makefile
# Verilator simulation of the CDC word bridge

VERILATOR ?= verilator
TOP       ?= tb_cdc_word_bridge
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
